// File: source/switch_pkg.sv
package switch_pkg;

    localparam int N_PORTS   = 4;
    localparam int SEL_W     = 2;
    localparam int DATA_W    = 8;
    localparam int VOQ_DEPTH = 4;
    localparam int CNT_W     = 3;
    localparam int PTR_W     = 2;

    // cell as offered at an ingress port
    typedef struct packed {
        logic              valid;
        logic [SEL_W-1:0]  dest;
        logic [DATA_W-1:0] data;
    } ingress_t;

    // cell inside the fabric tagged with its source port
    typedef struct packed {
        logic              valid;
        logic [SEL_W-1:0]  src;
        logic [SEL_W-1:0]  dest;
        logic [DATA_W-1:0] data;
    } cell_t;

endpackage

// File: source/slot_scheduler.sv
`timescale 1ns/10ps

module slot_scheduler (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  switch_pkg::ingress_t [switch_pkg::N_PORTS-1:0] ingress,
    input  logic [switch_pkg::N_PORTS-1:0]                 almost_full,
    output logic                                           ready,
    output logic [switch_pkg::SEL_W-1:0]                   slot,
    output switch_pkg::cell_t [switch_pkg::N_PORTS-1:0]    window
);

    import switch_pkg::*;

    logic                last_slot;
    cell_t [N_PORTS-1:0] tagged_cells;

    assign last_slot = (slot == SEL_W'(N_PORTS - 1));

    // accept only at the window boundary and only with room in every sub-queue
    assign ready = last_slot && !(|almost_full);

    // source tag is just the port index
    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            tagged_cells[p].valid = ingress[p].valid;
            tagged_cells[p].src   = SEL_W'(p);
            tagged_cells[p].dest  = ingress[p].dest;
            tagged_cells[p].data  = ingress[p].data;
        end
    end

    // window counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (last_slot) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // sampled window with one cell per port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window <= '0;
        end else if (ready) begin
            window <= tagged_cells;
        end else if (last_slot) begin
            // retire old cells at a stalled boundary so the shifter
            // does not hand them to the queues a second time
            for (int p = 0; p < N_PORTS; p++) begin
                window[p].valid <= 1'b0;
            end
        end
    end

endmodule

// File: source/barrel_shift.sv
`timescale 1ns/10ps

module barrel_shift (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [switch_pkg::SEL_W-1:0]                slot,
    input  switch_pkg::cell_t [switch_pkg::N_PORTS-1:0] window,
    output switch_pkg::cell_t [switch_pkg::N_PORTS-1:0] lanes
);

    import switch_pkg::*;

    cell_t [N_PORTS-1:0] rotated;

    // lane k takes port (k + slot) modulo N_PORTS
    always_comb begin
        for (int k = 0; k < N_PORTS; k++) begin
            rotated[k] = window[SEL_W'(k) + slot];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lanes <= '0;
        end else begin
            lanes <= rotated;
        end
    end

endmodule

// File: source/voq.sv
`timescale 1ns/10ps

module voq #(
    parameter int lane = 0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  switch_pkg::cell_t              lane_cell,
    input  logic [switch_pkg::SEL_W-1:0]   rd_sel,
    input  logic                           rd_en,
    output logic [switch_pkg::DATA_W-1:0]  rd_data,
    output logic [switch_pkg::N_PORTS-1:0] empty,
    output logic                           full,
    output logic                           almost_full
);

    import switch_pkg::*;

    // one circular sub-queue per source port
    logic [DATA_W-1:0]  mem [N_PORTS][VOQ_DEPTH];
    logic [PTR_W-1:0]   wr_ptr [N_PORTS];
    logic [PTR_W-1:0]   rd_ptr [N_PORTS];
    logic [CNT_W-1:0]   count [N_PORTS];

    logic               hit;
    logic [N_PORTS-1:0] push;
    logic [N_PORTS-1:0] pop;
    logic [N_PORTS-1:0] sub_full;
    logic [N_PORTS-1:0] sub_afull;

    // destination filter
    assign hit = lane_cell.valid && (lane_cell.dest == SEL_W'(lane));

    always_comb begin
        for (int q = 0; q < N_PORTS; q++) begin
            empty[q]     = (count[q] == '0);
            sub_full[q]  = (count[q] == CNT_W'(VOQ_DEPTH));
            sub_afull[q] = (count[q] >= CNT_W'(VOQ_DEPTH - 1));
            push[q]      = hit && (lane_cell.src == SEL_W'(q)) && !sub_full[q];
            // pop of an empty sub-queue is dropped here
            pop[q]       = rd_en && (rd_sel == SEL_W'(q)) && !empty[q];
        end
    end

    assign full        = |sub_full;
    assign almost_full = |sub_afull;

    // first-word-fall-through head of the selected sub-queue
    assign rd_data = mem[rd_sel][rd_ptr[rd_sel]];

    always_ff @(posedge clk) begin
        for (int q = 0; q < N_PORTS; q++) begin
            if (push[q]) begin
                mem[q][wr_ptr[q]] <= lane_cell.data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < N_PORTS; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q]  <= '0;
            end
        end else begin
            for (int q = 0; q < N_PORTS; q++) begin
                if (push[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                // simultaneous push and pop leaves the count alone
                case ({push[q], pop[q]})
                    2'b10:   count[q] <= count[q] + 1'b1;
                    2'b01:   count[q] <= count[q] - 1'b1;
                    default: count[q] <= count[q];
                endcase
            end
        end
    end

endmodule

// File: source/switch_core.sv
`timescale 1ns/10ps

module switch_core (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  switch_pkg::ingress_t [switch_pkg::N_PORTS-1:0]    ingress,
    output logic                                              ready,
    input  logic [switch_pkg::N_PORTS-1:0][switch_pkg::SEL_W-1:0]  rd_sel,
    input  logic [switch_pkg::N_PORTS-1:0]                    rd_en,
    output logic [switch_pkg::N_PORTS-1:0][switch_pkg::DATA_W-1:0] rd_data,
    output logic [switch_pkg::N_PORTS*switch_pkg::N_PORTS-1:0] empty,
    output logic                                              full
);

    import switch_pkg::*;

    logic [SEL_W-1:0]    slot;
    cell_t [N_PORTS-1:0] window;
    cell_t [N_PORTS-1:0] lanes;
    logic [N_PORTS-1:0]  lane_almost_full;
    logic [N_PORTS-1:0]  lane_full;

    slot_scheduler u_slot_scheduler (
        .clk         (clk),
        .rst_n       (rst_n),
        .ingress     (ingress),
        .almost_full (lane_almost_full),
        .ready       (ready),
        .slot        (slot),
        .window      (window)
    );

    barrel_shift u_barrel_shift (
        .clk    (clk),
        .rst_n  (rst_n),
        .slot   (slot),
        .window (window),
        .lanes  (lanes)
    );

    // one egress lane per output port with lane-major empty flags
    for (genvar k = 0; k < N_PORTS; k++) begin : g_lane
        voq #(
            .lane (k)
        ) u_voq (
            .clk         (clk),
            .rst_n       (rst_n),
            .lane_cell   (lanes[k]),
            .rd_sel      (rd_sel[k]),
            .rd_en       (rd_en[k]),
            .rd_data     (rd_data[k]),
            .empty       (empty[k*N_PORTS +: N_PORTS]),
            .full        (lane_full[k]),
            .almost_full (lane_almost_full[k])
        );
    end

    assign full = |lane_full;

endmodule

// File: tests/switch_checker.sv
`timescale 1ns/10ps

module switch_checker (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  switch_pkg::ingress_t [switch_pkg::N_PORTS-1:0]         ingress,
    input  logic                                                   ready,
    input  logic [switch_pkg::N_PORTS-1:0][switch_pkg::SEL_W-1:0]  rd_sel,
    input  logic [switch_pkg::N_PORTS-1:0]                         rd_en,
    input  logic [switch_pkg::N_PORTS-1:0][switch_pkg::DATA_W-1:0] rd_data,
    input  logic [switch_pkg::N_PORTS*switch_pkg::N_PORTS-1:0]     empty,
    input  logic                                                   full,
    input  logic                                                   check_flags,
    output int                                                     error_count
);

    import switch_pkg::*;

    // expected payloads in lane-major order like the empty flags
    logic [DATA_W-1:0] exp_q [N_PORTS*N_PORTS][$];

    function automatic int queue_of(input int dest, input int src);
        return dest * N_PORTS + src;
    endfunction

    // each valid payload of an accepted window joins its destination lane
    // behind older cells of the same source
    function automatic void reference_accept(input ingress_t [N_PORTS-1:0] cells);
        for (int p = 0; p < N_PORTS; p++) begin
            if (cells[p].valid) begin
                exp_q[queue_of(int'(cells[p].dest), p)].push_back(cells[p].data);
            end
        end
    endfunction

    function automatic void check_pop(input int lane, input int src);
        int q;
        q = queue_of(lane, src);
        // a sub-queue shown empty ignores the pop
        if (!empty[q]) begin
            if (exp_q[q].size() == 0) begin
                $display("FAIL t=%0t: lane %0d sub-queue %0d popped with nothing expected",
                         $time, lane, src);
                error_count++;
            end else begin
                if (rd_data[lane] !== exp_q[q][0]) begin
                    $display("FAIL t=%0t: lane %0d sub-queue %0d data %h, expected %h",
                             $time, lane, src, rd_data[lane], exp_q[q][0]);
                    error_count++;
                end
                void'(exp_q[q].pop_front());
            end
        end
    endfunction

    function automatic void compare_flags();
        logic exp_full;
        exp_full = 1'b0;
        for (int q = 0; q < N_PORTS * N_PORTS; q++) begin
            if (empty[q] !== (exp_q[q].size() == 0)) begin
                $display("FAIL t=%0t: empty[%0d] is %b, expected %b",
                         $time, q, empty[q], exp_q[q].size() == 0);
                error_count++;
            end
            if (exp_q[q].size() == VOQ_DEPTH) begin
                exp_full = 1'b1;
            end
        end
        if (full !== exp_full) begin
            $display("FAIL t=%0t: full is %b, expected %b", $time, full, exp_full);
            error_count++;
        end
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < N_PORTS * N_PORTS; q++) begin
                exp_q[q].delete();
            end
            error_count = 0;
        end else begin
            if (check_flags) begin
                compare_flags();
            end
            for (int lane = 0; lane < N_PORTS; lane++) begin
                if (rd_en[lane]) begin
                    check_pop(lane, int'(rd_sel[lane]));
                end
            end
            if (ready) begin
                reference_accept(ingress);
            end
        end
    end

endmodule

// File: tests/tb_switch.sv
`timescale 1ns/10ps

module tb_switch;

    import switch_pkg::*;

    logic                           clk;
    logic                           rst_n;
    ingress_t [N_PORTS-1:0]         ingress;
    logic                           ready;
    logic [N_PORTS-1:0][SEL_W-1:0]  rd_sel;
    logic [N_PORTS-1:0]             rd_en;
    logic [N_PORTS-1:0][DATA_W-1:0] rd_data;
    logic [N_PORTS*N_PORTS-1:0]     empty;
    logic                           full;
    logic                           check_flags;
    logic                           sending;
    int                             chk_errors;
    int                             tb_errors;
    int                             tests_run;
    int                             tests_failed;
    int                             errors_before;
    ingress_t [N_PORTS-1:0]         cells;

    switch_core u_switch_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .ingress (ingress),
        .ready   (ready),
        .rd_sel  (rd_sel),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .empty   (empty),
        .full    (full)
    );

    switch_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .ingress     (ingress),
        .ready       (ready),
        .rd_sel      (rd_sel),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .empty       (empty),
        .full        (full),
        .check_flags (check_flags),
        .error_count (chk_errors)
    );

    always #10 clk = ~clk;

    function automatic ingress_t make_cell(input int dest, input int data);
        ingress_t c;
        c.valid = 1'b1;
        c.dest  = SEL_W'(dest);
        c.data  = DATA_W'(data);
        return c;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic report(input string msg);
        $display("FAIL t=%0t: %s", $time, msg);
        tb_errors++;
    endtask

    // cells stay on the ports until a window boundary takes them
    task automatic send_cells(input ingress_t [N_PORTS-1:0] c, input int limit,
                              output bit taken);
        int n;
        n = 0;
        @(negedge clk);
        ingress = c;
        while (!ready && n < limit) begin
            @(negedge clk);
            n++;
        end
        taken = ready;
        @(negedge clk);
        ingress = '0;
    endtask

    task automatic send_or_abort(input ingress_t [N_PORTS-1:0] c, input int limit);
        bit taken;
        send_cells(c, limit, taken);
        if (!taken) begin
            abort_on_timeout("ready to accept a window");
        end
    endtask

    task automatic pop(input int lane, input int src);
        @(negedge clk);
        rd_sel[lane] = SEL_W'(src);
        rd_en[lane]  = 1'b1;
        @(negedge clk);
        rd_en[lane]  = 1'b0;
    endtask

    task automatic check_now;
        check_flags = 1'b1;
        @(negedge clk);
        check_flags = 1'b0;
    endtask

    // worst-case landing latency is N_PORTS+1 cycles
    task automatic settle_then_check;
        repeat (N_PORTS + 2) @(negedge clk);
        check_now();
    endtask

    task automatic wait_landed(input int idx, input int limit);
        int n;
        n = 0;
        while (empty[idx] && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (empty[idx]) begin
            abort_on_timeout("a cell to land in its sub-queue");
        end
    endtask

    task automatic drain_all;
        int n;
        for (int lane = 0; lane < N_PORTS; lane++) begin
            for (int src = 0; src < N_PORTS; src++) begin
                n = 0;
                while (!empty[lane*N_PORTS+src] && n < VOQ_DEPTH + 1) begin
                    pop(lane, src);
                    n++;
                end
                if (!empty[lane*N_PORTS+src]) begin
                    report($sformatf("lane %0d sub-queue %0d did not drain", lane, src));
                end
            end
        end
        check_now();
    endtask

    task automatic check_ready_period;
        int n;
        int gap;
        n = 0;
        while (!ready && n < 2 * N_PORTS) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            abort_on_timeout("the first ready pulse");
        end else begin
            for (int w = 0; w < 3; w++) begin
                gap = 0;
                do begin
                    @(negedge clk);
                    gap++;
                end while (!ready && gap < 2 * N_PORTS);
                if (gap != N_PORTS) begin
                    report($sformatf("ready period %0d cycles, expected %0d", gap, N_PORTS));
                end
            end
        end
    endtask

    task automatic random_traffic(input int windows);
        ingress_t [N_PORTS-1:0] c;
        int n;
        sending = 1'b1;
        fork
            begin
                for (int w = 0; w < windows; w++) begin
                    for (int p = 0; p < N_PORTS; p++) begin
                        c[p].valid = ($urandom_range(3) != 0);
                        c[p].dest  = SEL_W'($urandom_range(N_PORTS - 1));
                        c[p].data  = DATA_W'($urandom);
                    end
                    send_or_abort(c, 25 * N_PORTS);
                end
                sending = 1'b0;
            end
            begin
                n = 0;
                while (sending && n < 100 * windows) begin
                    @(negedge clk);
                    for (int lane = 0; lane < N_PORTS; lane++) begin
                        rd_sel[lane] = SEL_W'($urandom_range(N_PORTS - 1));
                        rd_en[lane]  = 1'($urandom_range(1));
                    end
                    n++;
                end
                rd_en = '0;
            end
        join
    endtask

    // source 0 to lane 2 with no reads until ingress stalls
    task automatic back_pressure;
        ingress_t [N_PORTS-1:0] c;
        bit taken;
        int n_taken;
        int held;
        int n;
        n_taken = 0;
        taken   = 1'b1;
        c       = '0;
        while (taken && n_taken < VOQ_DEPTH + 2) begin
            c[0] = make_cell(2, 'h50 + n_taken);
            send_cells(c, 3 * N_PORTS, taken);
            if (taken) begin
                n_taken++;
            end
        end
        if (taken) begin
            report("ready never dropped under back-pressure");
        end else if (n_taken < VOQ_DEPTH - 1) begin
            report($sformatf("ingress stalled after only %0d cells", n_taken));
        end
        settle_then_check();
        held = n_taken;
        while (held >= VOQ_DEPTH - 1) begin
            pop(2, 0);
            held--;
            n = 0;
            while (!ready && n <= N_PORTS) begin
                @(negedge clk);
                n++;
            end
            if (held >= VOQ_DEPTH - 1 && ready) begin
                report("ready rose while a sub-queue was almost full");
            end else if (held < VOQ_DEPTH - 1 && !ready) begin
                report("ready did not return after draining");
            end
        end
        drain_all();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (chk_errors + tb_errors != errors_before) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        errors_before = chk_errors + tb_errors;
    endtask

    initial begin
        void'($urandom(3435));
        clk           = 1'b0;
        rst_n         = 1'b0;
        ingress       = '0;
        rd_sel        = '0;
        rd_en         = '0;
        check_flags   = 1'b0;
        sending       = 1'b0;
        tb_errors     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_now();
        check_ready_period();
        end_test("reset_and_ready");

        cells    = '0;
        cells[2] = make_cell(1, $urandom_range(255));
        send_or_abort(cells, 3 * N_PORTS);
        wait_landed(1 * N_PORTS + 2, N_PORTS + 1);
        check_now();
        pop(1, 2);
        check_now();
        end_test("single_cell");

        for (int p = 0; p < N_PORTS; p++) begin
            cells[p] = make_cell(3, $urandom_range(255));
        end
        send_or_abort(cells, 3 * N_PORTS);
        settle_then_check();
        for (int s = 0; s < N_PORTS; s++) begin
            pop(3, s);
        end
        check_now();
        end_test("fan_in");

        random_traffic(40);
        settle_then_check();
        drain_all();
        end_test("random_traffic");

        back_pressure();
        end_test("back_pressure");

        // pops of empty sub-queues around one real cell
        cells    = '0;
        cells[1] = make_cell(0, $urandom_range(255));
        send_or_abort(cells, 3 * N_PORTS);
        settle_then_check();
        pop(0, 3);
        pop(2, 1);
        check_now();
        pop(0, 1);
        check_now();
        end_test("empty_pop");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 chk_errors + tb_errors);
        if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/switch_pkg.sv
source/slot_scheduler.sv
source/barrel_shift.sv
source/voq.sv
source/switch_core.sv
tests/switch_checker.sv
tests/tb_switch.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_switch -f filelist.f -o tb_switch

output=$(./obj_dir/tb_switch)
echo "$output"

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
